// File: logic/runner_pkg.sv
// shared types for the runner game: coordinates, velocity, colour
// sprite sizes, jump physics and the scene palette
package runner_pkg;

    typedef logic        [11:0] coord_t;  // screen column, line or box edge
    typedef logic signed [11:0] vel_t;    // pixels per frame, negative is upward
    typedef logic        [11:0] rgb_t;    // 4 bits each of red, green, blue

    // dinosaur geometry, all measured from the sprite centre
    localparam coord_t DINO_X      = 12'd12;  // fixed horizontal centre
    localparam coord_t DINO_HALF_W = 12'd3;
    localparam coord_t DINO_HALF_H = 12'd5;   // standing
    localparam coord_t DUCK_HALF_H = 12'd3;   // crouching

    // jump physics
    localparam coord_t JUMP_STRENGTH = 12'd6;  // launch speed, upward
    localparam coord_t GRAVITY       = 12'd1;  // added to velocity every frame

    // cactus geometry
    localparam coord_t CACTUS_HALF_W = 12'd2;
    localparam coord_t CACTUS_HALF_H = 12'd4;

    // palette, 12'hRGB
    localparam rgb_t SKY_RGB    = 12'h6cf;  // pale blue
    localparam rgb_t FLOOR_RGB  = 12'h863;  // brown ground
    localparam rgb_t DINO_RGB   = 12'h373;  // dark green
    localparam rgb_t CACTUS_RGB = 12'h0a0;  // bright green
    localparam rgb_t HIT_RGB    = 12'hf00;  // red where the sprites touch

endpackage

// File: logic/sprite_box_if.sv
// bounding box of one sprite, passed from a motion block to the renderer
interface sprite_box_if;

    runner_pkg::coord_t x1;  // left edge, inclusive
    runner_pkg::coord_t x2;  // right edge, inclusive
    runner_pkg::coord_t y1;  // top edge, inclusive
    runner_pkg::coord_t y2;  // bottom edge, inclusive

    // motion side drives the edges
    modport src (
        output x1, x2, y1, y2
    );

    // renderer side only looks at them
    modport dst (
        input x1, x2, y1, y2
    );

endinterface

// File: logic/vga_timing.sv
// vga raster counters with sync and data-enable decode
// plus a one-cycle strobe at the start of vertical blanking
module vga_timing #(
    parameter runner_pkg::coord_t H_ACTIVE = 12'd640,
    parameter runner_pkg::coord_t H_FRONT  = 12'd16,
    parameter runner_pkg::coord_t H_SYNC   = 12'd96,
    parameter runner_pkg::coord_t H_BACK   = 12'd48,
    parameter runner_pkg::coord_t V_ACTIVE = 12'd480,
    parameter runner_pkg::coord_t V_FRONT  = 12'd10,
    parameter runner_pkg::coord_t V_SYNC   = 12'd2,
    parameter runner_pkg::coord_t V_BACK   = 12'd33
) (
    input  logic               i_clk,
    input  logic               i_rst,
    output runner_pkg::coord_t o_h,         // current column
    output runner_pkg::coord_t o_v,         // current line
    output logic               o_hsync,     // active low
    output logic               o_vsync,     // active low
    output logic               o_de,        // inside the visible area
    output logic               o_frame_stb  // first cycle of vertical blanking
);

    // full line and frame lengths
    localparam runner_pkg::coord_t H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam runner_pkg::coord_t V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    // sync pulse windows, start inclusive and end exclusive
    localparam runner_pkg::coord_t HS_START = H_ACTIVE + H_FRONT;
    localparam runner_pkg::coord_t HS_END   = HS_START + H_SYNC;
    localparam runner_pkg::coord_t VS_START = V_ACTIVE + V_FRONT;
    localparam runner_pkg::coord_t VS_END   = VS_START + V_SYNC;

    runner_pkg::coord_t h;
    runner_pkg::coord_t v;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            h <= '0;
            v <= '0;
        end else if (h == H_TOTAL - 1'b1) begin  // end of line
            h <= '0;
            if (v == V_TOTAL - 1'b1)               // end of frame
                v <= '0;
            else
                v <= v + 1'b1;
        end else begin
            h <= h + 1'b1;
        end
    end

    assign o_h = h;
    assign o_v = v;

    // decode straight from the counters, the renderer registers these
    assign o_hsync = ~((h >= HS_START) && (h < HS_END));
    assign o_vsync = ~((v >= VS_START) && (v < VS_END));
    assign o_de    = (h < H_ACTIVE) && (v < V_ACTIVE);

    // sprites may move from here on without tearing the picture
    assign o_frame_stb = (h == '0) && (v == V_ACTIVE);

endmodule

// File: logic/dino_motion.sv
// dinosaur vertical motion: jump under gravity, landing clamp and crouch
// drives the dinosaur bounding box once per frame
module dino_motion #(
    parameter runner_pkg::coord_t FLOOR_Y = 12'd400
) (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_frame_stb,  // one pulse per frame in vertical blanking
    input  logic         i_run,        // game running
    input  logic         i_game_over,  // freezes everything once set
    input  logic         i_jump,       // jump button, sampled at the strobe
    input  logic         i_duck,       // duck button, sampled at the strobe
    sprite_box_if.src    box
);

    runner_pkg::coord_t y;        // centre line of the sprite
    runner_pkg::vel_t   vel;      // current vertical speed
    logic               jumping;  // airborne
    runner_pkg::coord_t half_h;   // current half-height

    logic               step;     // advance the motion this cycle
    runner_pkg::vel_t   y_fall;   // centre after one step of flight, may go above line 0
    runner_pkg::vel_t   bot_fall; // bottom edge after that step
    runner_pkg::coord_t ground_h; // half-height picked on the ground

    assign step = i_frame_stb && i_run && !i_game_over;

    // flight maths done signed so a high jump off the top is not seen as landed
    assign y_fall   = runner_pkg::vel_t'(y) + vel;
    assign bot_fall = y_fall + runner_pkg::vel_t'(half_h);

    assign ground_h = i_duck ? runner_pkg::DUCK_HALF_H : runner_pkg::DINO_HALF_H;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            y       <= FLOOR_Y - 1'b1 - runner_pkg::DINO_HALF_H;  // standing on the floor
            vel     <= '0;
            jumping <= 1'b0;
            half_h  <= runner_pkg::DINO_HALF_H;
        end else if (step) begin
            if (jumping) begin
                if (bot_fall >= runner_pkg::vel_t'(FLOOR_Y)) begin
                    // touched down, snap the bottom onto the floor line
                    y       <= FLOOR_Y - 1'b1 - half_h;
                    vel     <= '0;
                    jumping <= 1'b0;
                end else begin
                    y   <= runner_pkg::coord_t'(y_fall);               // old speed moves us
                    vel <= vel + runner_pkg::vel_t'(runner_pkg::GRAVITY); // then gravity acts
                end
            end else if (i_jump) begin
                jumping <= 1'b1;                                       // take off
                vel     <= -runner_pkg::vel_t'(runner_pkg::JUMP_STRENGTH);
                y       <= y - runner_pkg::JUMP_STRENGTH;
                half_h  <= runner_pkg::DINO_HALF_H;                    // always jump upright
            end else begin
                // on the ground, crouch or stand with the feet kept in place
                half_h <= ground_h;
                y      <= FLOOR_Y - 1'b1 - ground_h;
            end
        end
    end

    // horizontal position never changes
    assign box.x1 = runner_pkg::DINO_X - runner_pkg::DINO_HALF_W;
    assign box.x2 = runner_pkg::DINO_X + runner_pkg::DINO_HALF_W;
    assign box.y1 = y - half_h;  // top
    assign box.y2 = y + half_h;  // bottom

endmodule

// File: logic/obstacle_scroll.sv
// cactus obstacle scrolling right to left, wrapping back to the right edge
module obstacle_scroll #(
    parameter runner_pkg::coord_t H_ACTIVE     = 12'd640,
    parameter runner_pkg::coord_t FLOOR_Y      = 12'd400,
    parameter runner_pkg::coord_t CACTUS_SPEED = 12'd4
) (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_frame_stb,  // one pulse per frame
    input  logic         i_run,
    input  logic         i_game_over,
    sprite_box_if.src    box
);

    // centre that puts the right edge on the last visible column
    localparam runner_pkg::coord_t START_X = H_ACTIVE - 1'b1 - runner_pkg::CACTUS_HALF_W;

    runner_pkg::coord_t cx;    // horizontal centre
    logic               step;  // advance this cycle
    logic               wrap;  // next step would push the left edge past column 0

    assign step = i_frame_stb && i_run && !i_game_over;
    // compare before subtracting so the unsigned centre never underflows
    assign wrap = cx < (runner_pkg::CACTUS_HALF_W + CACTUS_SPEED);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cx <= START_X;
        end else if (step) begin
            if (wrap)
                cx <= START_X;  // reappear at the right
            else
                cx <= cx - CACTUS_SPEED;
        end
    end

    assign box.x1 = cx - runner_pkg::CACTUS_HALF_W;
    assign box.x2 = cx + runner_pkg::CACTUS_HALF_W;
    // standing on the floor, 2*half+1 lines tall
    assign box.y1 = FLOOR_Y - 1'b1 - (runner_pkg::CACTUS_HALF_H << 1);
    assign box.y2 = FLOOR_Y - 1'b1;

endmodule

// File: logic/scene_render.sv
// per-pixel scene colour with registered sync and data-enable
// and the sticky game-over flag on the first sprite overlap
module scene_render #(
    parameter runner_pkg::coord_t FLOOR_Y = 12'd400
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  runner_pkg::coord_t i_h,      // column from the counters
    input  runner_pkg::coord_t i_v,      // line from the counters
    input  logic               i_hsync,
    input  logic               i_vsync,
    input  logic               i_de,
    sprite_box_if.dst          dino,
    sprite_box_if.dst          cactus,
    output logic               o_hsync,
    output logic               o_vsync,
    output logic               o_de,
    output logic               o_game_over,
    output runner_pkg::rgb_t   o_rgb
);

    logic             in_dino;    // pixel inside the dinosaur box
    logic             in_cactus;  // pixel inside the cactus box
    logic             hit;        // visible pixel where both overlap
    runner_pkg::rgb_t colour;     // colour of the current pixel

    assign in_dino   = (i_h >= dino.x1) && (i_h <= dino.x2) &&
                       (i_v >= dino.y1) && (i_v <= dino.y2);
    assign in_cactus = (i_h >= cactus.x1) && (i_h <= cactus.x2) &&
                       (i_v >= cactus.y1) && (i_v <= cactus.y2);
    assign hit       = i_de && in_dino && in_cactus;

    // priority: blank, overlap, dinosaur, cactus, floor, sky
    always_comb begin
        if (!i_de)
            colour = '0;
        else if (in_dino && in_cactus)
            colour = runner_pkg::HIT_RGB;
        else if (in_dino)
            colour = runner_pkg::DINO_RGB;
        else if (in_cactus)
            colour = runner_pkg::CACTUS_RGB;
        else if (i_v >= FLOOR_Y)
            colour = runner_pkg::FLOOR_RGB;
        else
            colour = runner_pkg::SKY_RGB;
    end

    // control outputs and the latch
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_hsync     <= 1'b1;  // sync idle high
            o_vsync     <= 1'b1;
            o_de        <= 1'b0;
            o_game_over <= 1'b0;
        end else begin
            o_hsync <= i_hsync;
            o_vsync <= i_vsync;
            o_de    <= i_de;
            if (hit)
                o_game_over <= 1'b1;  // sticky until reset
        end
    end

    // pixel data, lines up with the sync outputs above
    always_ff @(posedge i_clk) begin
        o_rgb <= colour;
    end

endmodule

// File: logic/runner_top.sv
// runner game top level: raster timing, sprite motion and scene rendering
module runner_top #(
    parameter runner_pkg::coord_t H_ACTIVE     = 12'd640,
    parameter runner_pkg::coord_t H_FRONT      = 12'd16,
    parameter runner_pkg::coord_t H_SYNC       = 12'd96,
    parameter runner_pkg::coord_t H_BACK       = 12'd48,
    parameter runner_pkg::coord_t V_ACTIVE     = 12'd480,
    parameter runner_pkg::coord_t V_FRONT      = 12'd10,
    parameter runner_pkg::coord_t V_SYNC       = 12'd2,
    parameter runner_pkg::coord_t V_BACK       = 12'd33,
    parameter runner_pkg::coord_t FLOOR_Y      = 12'd400,  // top line of the floor
    parameter runner_pkg::coord_t CACTUS_SPEED = 12'd4     // pixels per frame
) (
    input  logic             i_clk,        // pixel clock
    input  logic             i_rst,
    input  logic             i_run,        // low pauses the game
    input  logic             i_jump,
    input  logic             i_duck,
    output logic             o_hsync,
    output logic             o_vsync,
    output logic             o_de,
    output logic             o_game_over,
    output runner_pkg::rgb_t o_rgb
);

    runner_pkg::coord_t h;          // raster column
    runner_pkg::coord_t v;          // raster line
    logic               hsync;      // decoded straight from the counters
    logic               vsync;
    logic               de;
    logic               frame_stb;

    sprite_box_if dino_box ();
    sprite_box_if cactus_box ();

    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) timing_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .o_h         (h),
        .o_v         (v),
        .o_hsync     (hsync),
        .o_vsync     (vsync),
        .o_de        (de),
        .o_frame_stb (frame_stb)
    );

    dino_motion #(
        .FLOOR_Y (FLOOR_Y)
    ) dino_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_frame_stb (frame_stb),
        .i_run       (i_run),
        .i_game_over (o_game_over),  // freeze after a collision
        .i_jump      (i_jump),
        .i_duck      (i_duck),
        .box         (dino_box)
    );

    obstacle_scroll #(
        .H_ACTIVE     (H_ACTIVE),
        .FLOOR_Y      (FLOOR_Y),
        .CACTUS_SPEED (CACTUS_SPEED)
    ) cactus_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_frame_stb (frame_stb),
        .i_run       (i_run),
        .i_game_over (o_game_over),
        .box         (cactus_box)
    );

    scene_render #(
        .FLOOR_Y (FLOOR_Y)
    ) render_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_h         (h),
        .i_v         (v),
        .i_hsync     (hsync),
        .i_vsync     (vsync),
        .i_de        (de),
        .dino        (dino_box),
        .cactus      (cactus_box),
        .o_hsync     (o_hsync),
        .o_vsync     (o_vsync),
        .o_de        (o_de),
        .o_game_over (o_game_over),
        .o_rgb       (o_rgb)
    );

endmodule

// File: tb/runner_sva.sv
// bound checks on the frame strobe, vsync against data-enable
// and the sticky game-over flag
module runner_sva (
    input logic i_clk,
    input logic i_rst,
    input logic i_frame_stb,  // internal strobe of the top level
    input logic i_de,         // registered data-enable
    input logic i_vsync,      // registered vsync, active low
    input logic i_game_over
);
    timeunit 1ns;
    timeprecision 100ps;

    // strobe lasts a single pixel clock
    a_stb_width: assert property (@(posedge i_clk) disable iff (i_rst)
        i_frame_stb |=> !i_frame_stb)
        else $error("frame strobe high for more than one cycle");

    // no visible pixels during the vsync pulse
    a_de_vsync: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_de && !i_vsync))
        else $error("data-enable high while vsync is active");

    // game over only clears through reset
    a_go_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
        i_game_over |=> i_game_over)
        else $error("game-over flag fell without reset");

endmodule

bind runner_top runner_sva sva_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_frame_stb (frame_stb),
    .i_de        (o_de),
    .i_vsync     (o_vsync),
    .i_game_over (o_game_over)
);

// File: tb/runner_tb.sv
// runner game testbench: clock, reset, scripted and lfsr buttons
// frame-level reference model, per-pixel compare, raster sync check and watchdog
module runner_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // tiny screen so whole frames run fast
    localparam int H_ACT = 48;
    localparam int V_ACT = 32;
    localparam int FRONT = 2;
    localparam int SYNC  = 4;
    localparam int BACK  = 2;
    localparam int FLOOR = 26;
    localparam int SPEED = 3;
    localparam int CLK_NS     = 4;
    localparam int NUM_FRAMES = 32;   // collision lands in frame 27
    localparam int H_TOTAL      = H_ACT + FRONT + SYNC + BACK;
    localparam int V_TOTAL      = V_ACT + FRONT + SYNC + BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_NS   = (NUM_FRAMES + 2) * FRAME_CYCLES * CLK_NS + 1000;
    localparam logic [31:0] SEED = 32'h2b27cc03;

    // package values as signed ints for the model maths
    localparam int DINO_XC  = int'(runner_pkg::DINO_X);
    localparam int DINO_HW  = int'(runner_pkg::DINO_HALF_W);
    localparam int STAND_HH = int'(runner_pkg::DINO_HALF_H);
    localparam int DUCK_HH  = int'(runner_pkg::DUCK_HALF_H);
    localparam int JUMP_V   = int'(runner_pkg::JUMP_STRENGTH);
    localparam int GRAV     = int'(runner_pkg::GRAVITY);
    localparam int CACT_HW  = int'(runner_pkg::CACTUS_HALF_W);
    localparam int CACT_HH  = int'(runner_pkg::CACTUS_HALF_H);

    logic             i_clk;
    logic             i_rst;
    logic             i_run;
    logic             i_jump;
    logic             i_duck;
    logic             o_hsync;
    logic             o_vsync;
    logic             o_de;
    logic             o_game_over;
    runner_pkg::rgb_t o_rgb;

    // reference state, updated once per strobe
    int          m_y;          // dinosaur centre, may go above line 0
    int          m_vel;
    int          m_half_h;
    int          m_cx;         // cactus centre
    logic        m_jumping;
    logic        m_game_over;
    logic [31:0] lfsr_state;
    logic        stop_reported = 1'b0;  // set once a verdict is printed

    runner_top #(
        .H_ACTIVE (runner_pkg::coord_t'(H_ACT)), .H_FRONT (runner_pkg::coord_t'(FRONT)),
        .H_SYNC   (runner_pkg::coord_t'(SYNC)),  .H_BACK  (runner_pkg::coord_t'(BACK)),
        .V_ACTIVE (runner_pkg::coord_t'(V_ACT)), .V_FRONT (runner_pkg::coord_t'(FRONT)),
        .V_SYNC   (runner_pkg::coord_t'(SYNC)),  .V_BACK  (runner_pkg::coord_t'(BACK)),
        .FLOOR_Y  (runner_pkg::coord_t'(FLOOR)), .CACTUS_SPEED (runner_pkg::coord_t'(SPEED))
    ) dut_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_run       (i_run),
        .i_jump      (i_jump),
        .i_duck      (i_duck),
        .o_hsync     (o_hsync),
        .o_vsync     (o_vsync),
        .o_de        (o_de),
        .o_game_over (o_game_over),
        .o_rgb       (o_rgb)
    );

    // right-shift galois lfsr, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hA3000000 : 32'h0);
    endfunction

    function logic next_bit();
        lfsr_state = lfsr_step(lfsr_state);  // one step per bit taken
        return lfsr_state[0];
    endfunction

    // buttons for strobe s
    task automatic drive_inputs(input int s);
        logic run;
        logic jump;
        logic duck;
        run  = 1'b1;
        jump = 1'b0;
        duck = 1'b0;
        if (s <= 1) begin
            duck = 1'b1;                      // crouch on the ground
        end else if (s == 3 || s == 4) begin
            run  = 1'b0;                      // paused, presses must do nothing
            jump = 1'b1;
            duck = (s == 3);
        end else if (s == 5) begin
            jump = 1'b1;                      // take off over the cactus
        end else if (s >= 6 && s <= 19) begin
            jump = next_bit();                // airborne, ignored
            duck = next_bit();
        end else if (s >= 27) begin
            run  = next_bit();                // after the crash
            jump = next_bit();
            duck = next_bit();
        end
        i_run  = run;                         // s20..s26 nothing pressed, cactus hits
        i_jump = jump;
        i_duck = duck;
    endtask

    // motion rules at one strobe
    function automatic void update_model(input logic run, input logic jump, input logic duck);
        int y_next;
        if (!run || m_game_over)
            return;                           // frozen
        if (m_jumping) begin
            y_next = m_y + m_vel;             // old speed moves first
            if (y_next + m_half_h >= FLOOR) begin
                m_y       = FLOOR - 1 - m_half_h;  // land on the floor line
                m_vel     = 0;
                m_jumping = 1'b0;
            end else begin
                m_y   = y_next;
                m_vel = m_vel + GRAV;
            end
        end else if (jump) begin
            m_jumping = 1'b1;
            m_vel     = -JUMP_V;
            m_y       = m_y - JUMP_V;
            m_half_h  = STAND_HH;
        end else begin
            m_half_h = duck ? DUCK_HH : STAND_HH;
            m_y      = FLOOR - 1 - m_half_h;  // feet stay put
        end
        if (m_cx - SPEED < CACT_HW)
            m_cx = H_ACT - 1 - CACT_HW;       // wrap to the right edge
        else
            m_cx = m_cx - SPEED;
    endfunction

    // expected colour of one visible pixel
    function automatic runner_pkg::rgb_t expected_rgb(input runner_pkg::coord_t col,
                                                      input runner_pkg::coord_t line);
        runner_pkg::coord_t dx1;
        runner_pkg::coord_t dx2;
        runner_pkg::coord_t dy1;
        runner_pkg::coord_t dy2;
        runner_pkg::coord_t cx1;
        runner_pkg::coord_t cx2;
        runner_pkg::coord_t cy1;
        runner_pkg::coord_t cy2;
        logic in_d;
        logic in_c;
        dx1 = runner_pkg::coord_t'(DINO_XC - DINO_HW);
        dx2 = runner_pkg::coord_t'(DINO_XC + DINO_HW);
        dy1 = runner_pkg::coord_t'(m_y - m_half_h);  // 12-bit edges wrap above line 0
        dy2 = runner_pkg::coord_t'(m_y + m_half_h);
        cx1 = runner_pkg::coord_t'(m_cx - CACT_HW);
        cx2 = runner_pkg::coord_t'(m_cx + CACT_HW);
        cy1 = runner_pkg::coord_t'(FLOOR - 1 - 2 * CACT_HH);
        cy2 = runner_pkg::coord_t'(FLOOR - 1);
        in_d = (col >= dx1) && (col <= dx2) && (line >= dy1) && (line <= dy2);
        in_c = (col >= cx1) && (col <= cx2) && (line >= cy1) && (line <= cy2);
        if (in_d && in_c)
            return runner_pkg::HIT_RGB;
        else if (in_d)
            return runner_pkg::DINO_RGB;
        else if (in_c)
            return runner_pkg::CACTUS_RGB;
        else if (line >= runner_pkg::coord_t'(FLOOR))
            return runner_pkg::FLOOR_RGB;
        else
            return runner_pkg::SKY_RGB;
    endfunction

    task automatic check_rgb(input string name, input runner_pkg::rgb_t exp,
                             input runner_pkg::rgb_t act);
        if (exp !== act) begin
            stop_reported = 1'b1;
            $display("Error: %s rgb expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "pixel colour mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            stop_reported = 1'b1;
            $display("Error: %s expected %b actual %b", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "control flag mismatch");
        end
    endtask

    initial begin : clock_gen
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    initial begin : reset_gen
        i_rst = 1'b1;
        repeat (3) @(negedge i_clk);  // three rising edges in reset
        i_rst = 1'b0;
    end

    // new buttons at each vsync, sampled by the next strobe
    initial begin : stimulus
        int n;
        lfsr_state = SEED;
        drive_inputs(0);
        @(negedge i_rst);
        for (n = 0; n < NUM_FRAMES; n++) begin
            @(negedge o_vsync);
            @(negedge i_clk);
            drive_inputs(n + 1);
        end
    end

    // syncs and data-enable against the raster position, one cycle behind the counters
    initial begin : raster_check
        int pos;
        int col;
        int row;
        logic exp_hs;
        logic exp_vs;
        logic exp_de;
        string name;
        pos = 0;
        @(negedge i_rst);
        forever begin
            @(negedge i_clk);
            col    = pos % H_TOTAL;
            row    = (pos / H_TOTAL) % V_TOTAL;
            exp_hs = !((col >= H_ACT + FRONT) && (col < H_ACT + FRONT + SYNC));  // active low
            exp_vs = !((row >= V_ACT + FRONT) && (row < V_ACT + FRONT + SYNC));
            exp_de = (col < H_ACT) && (row < V_ACT);
            name   = $sformatf("raster (%0d,%0d)", col, row);
            check_flag({name, " hsync"}, exp_hs, o_hsync);
            check_flag({name, " vsync"}, exp_vs, o_vsync);
            check_flag({name, " de"}, exp_de, o_de);
            pos++;
        end
    end

    initial begin : compare
        int f;
        int line;
        int col;
        runner_pkg::rgb_t exp;
        string name;
        m_y         = FLOOR - 1 - STAND_HH;   // standing after reset
        m_vel       = 0;
        m_half_h    = STAND_HH;
        m_cx        = H_ACT - 1 - CACT_HW;
        m_jumping   = 1'b0;
        m_game_over = 1'b0;
        @(negedge i_rst);
        for (f = 0; f < NUM_FRAMES; f++) begin
            for (line = 0; line < V_ACT; line++) begin
                for (col = 0; col < H_ACT; col++) begin
                    @(negedge i_clk);
                    while (!o_de) @(negedge i_clk);  // skip blanking
                    exp = expected_rgb(runner_pkg::coord_t'(col), runner_pkg::coord_t'(line));
                    if (exp == runner_pkg::HIT_RGB)
                        m_game_over = 1'b1;          // rises with the first red pixel
                    name = $sformatf("frame %0d pixel (%0d,%0d)", f, col, line);
                    check_rgb(name, exp, o_rgb);
                    check_flag({name, " game_over"}, m_game_over, o_game_over);
                end
            end
            // strobe is next, buttons still hold what it samples
            update_model(i_run, i_jump, i_duck);
        end
        check_flag("game_over at end of run", 1'b1, o_game_over);
        stop_reported = 1'b1;
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_reported = 1'b1;
        $display("Timeout: %0d frames were not checked within %0d ns", NUM_FRAMES, TIMEOUT_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // run stopped early, e.g. by a bound assertion
    final begin
        if (!stop_reported) begin
            $display("The simulation stopped before all frames were checked");
            $display("TESTS FAILED");
        end
    end

endmodule

// File: project.f
logic/runner_pkg.sv
logic/sprite_box_if.sv
logic/vga_timing.sv
logic/dino_motion.sv
logic/obstacle_scroll.sv
logic/scene_render.sv
logic/runner_top.sv
tb/runner_sva.sv
tb/runner_tb.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv tb/*.sv)

all: run

obj_dir/Vrunner_tb: project.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module runner_tb -f project.f

run: obj_dir/Vrunner_tb
	-./obj_dir/Vrunner_tb | tee sim.log
	@! grep -q "TESTS FAILED" sim.log
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
